// ==== src.f ====
+incdir+source
source/vmul_pkg.sv
source/vmul_ctrl.sv
source/vmul_operand_shift.sv
source/vmul_lane_array.sv
source/vmul_result_collect.sv
source/vmul_unit.sv
test/vmul_unit_asserts.sv
test/tb_vmul_unit.sv

// ==== Bender.yml ====
package:
  name: vmul_unit

export_include_dirs:
  - source

sources:
  - files:
      - source/vmul_pkg.sv
      - source/vmul_ctrl.sv
      - source/vmul_operand_shift.sv
      - source/vmul_lane_array.sv
      - source/vmul_result_collect.sv
      - source/vmul_unit.sv
  - target: test
    files:
      - test/vmul_unit_asserts.sv
      - test/tb_vmul_unit.sv

// ==== test/tb_vmul_unit.sv ====
// testbench for the vector multiply unit
// random requests under response back-pressure, checked against a reference model

`timescale 1ns/1ps

`include "vmul_config.svh"

module tb_vmul_unit import vmul_pkg::*; ();

    localparam int unsigned VREG_W  = `VMUL_VREG_W;
    localparam int unsigned NBYTES  = `VMUL_VREG_W / 8;
    localparam int unsigned VL_W    = `VMUL_VL_W;
    localparam int unsigned NUM_OPS = 300;
    localparam int unsigned TIMEOUT = 200;

    logic        clk_i;
    logic        async_rst_ni;
    logic        req_valid_i;
    vmul_req_t   req_i;
    logic        req_ready_o;
    logic        resp_valid_o;
    vmul_resp_t  resp_o;
    logic        resp_ready_i;
    int unsigned n_resp;
    int unsigned n_accept;

    vmul_unit UUT (
        .clk_i        ( clk_i        ),
        .async_rst_ni ( async_rst_ni ),
        .req_valid_i  ( req_valid_i  ),
        .req_i        ( req_i        ),
        .req_ready_o  ( req_ready_o  ),
        .resp_valid_o ( resp_valid_o ),
        .resp_o       ( resp_o       ),
        .resp_ready_i ( resp_ready_i )
    );

    always #2 clk_i = ~clk_i;

    // transfers seen on the ports, to catch lost or extra handshakes
    always @(posedge clk_i) begin
        if (async_rst_ni && req_valid_i && req_ready_o) begin
            n_accept <= n_accept + 1;
        end
        if (async_rst_ni && resp_valid_o && resp_ready_i) begin
            n_resp <= n_resp + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model

    // sign or zero extension of a w-bit element to 64 bits
    function automatic logic [63:0] extend(input logic [31:0] v, input int w, input bit sgn);
        logic [63:0] mask;
        logic [63:0] r;
        mask = (64'd1 << w) - 64'd1;
        r    = {32'd0, v} & mask;
        if (sgn && v[w-1]) begin
            r = r | ~mask;
        end
        return r;
    endfunction

    function automatic logic [VREG_W-1:0] model_vd(input vmul_req_t req);
        int                esize;
        logic [63:0]       mask;
        logic [63:0]       a, b, c, e;
        logic [VREG_W-1:0] elem;
        logic [VREG_W-1:0] vd;
        esize = 8 << int'(req.mode.sew);
        mask  = (64'd1 << esize) - 64'd1;
        vd    = '0;
        for (int k = 0; k < int'(VREG_W) / esize; k++) begin
            a = extend(32'(req.vs1 >> (k * esize)), esize, req.mode.op1_signed);
            b = extend(32'(req.vs2 >> (k * esize)), esize, req.mode.op2_signed);
            c = {32'd0, 32'(req.vs3 >> (k * esize))} & mask;
            // 64 bits hold the full double-width product for every width
            case (req.mode.op)
                MUL_VMULH: e = ((a * b) >> esize) & mask;
                MUL_VMACC: e = (a * b + c) & mask;
                default:   e = (a * b) & mask;
            endcase
            elem = '0;
            elem[63:0] = e;
            vd = vd | (elem << (k * esize));
        end
        return vd;
    endfunction

    function automatic logic [NBYTES-1:0] model_be(input vmul_sew_e sew,
                                                   input logic [VL_W-1:0] vl);
        logic [NBYTES-1:0] be;
        for (int j = 0; j < int'(NBYTES); j++) begin
            be[j] = (j / (1 << int'(sew))) < int'(vl);
        end
        return be;
    endfunction

    // the first 36 requests sweep every operation, width and signedness
    function automatic vmul_req_t make_request(input int idx);
        vmul_req_t r;
        int        nelem;
        if (idx < 36) begin
            r.mode.op         = vmul_op_e'(idx % 3);
            r.mode.sew        = vmul_sew_e'((idx / 3) % 3);
            r.mode.op1_signed = ((idx / 9) & 2) != 0;
            r.mode.op2_signed = ((idx / 9) & 1) != 0;
        end else begin
            r.mode.op         = vmul_op_e'($urandom_range(0, 2));
            r.mode.sew        = vmul_sew_e'($urandom_range(0, 2));
            r.mode.op1_signed = $urandom_range(0, 1) == 1;
            r.mode.op2_signed = $urandom_range(0, 1) == 1;
        end
        nelem = int'(NBYTES) >> int'(r.mode.sew);
        case (idx % 4)
            0:       r.vl = '0;
            1:       r.vl = VL_W'(nelem);
            default: r.vl = VL_W'($urandom_range(0, nelem));
        endcase
        for (int w = 0; w < int'(VREG_W) / 32; w++) begin
            r.vs1[32*w +: 32] = $urandom;
            r.vs2[32*w +: 32] = $urandom;
            r.vs3[32*w +: 32] = $urandom;
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // checking

    task automatic end_in_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_equal(input logic [VREG_W-1:0] got, input logic [VREG_W-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %0h expected %0h", $time, what, got, exp);
            end_in_failure();
        end
    endtask

    // one request through both handshakes, with random back-pressure
    task automatic run_op(input vmul_req_t req);
        logic [VREG_W-1:0] exp_vd;
        logic [NBYTES-1:0] exp_be;
        int unsigned       edges;
        bit                seen;
        bit                done;
        exp_vd = model_vd(req);
        exp_be = model_be(req.mode.sew, req.vl);
        @(negedge clk_i);
        // the previous response must not show up twice
        check_equal(VREG_W'(resp_valid_o), '0, "resp_valid_o after response handshake");
        req_valid_i  = 1'b1;
        req_i        = req;
        resp_ready_i = 1'b0;
        edges        = 0;
        while (!req_ready_o) begin
            @(negedge clk_i);
            edges++;
            if (edges > TIMEOUT) begin
                $display("timeout: request handshake hung, req_ready_o never rose");
                end_in_failure();
            end
        end
        edges = 0;
        seen  = 1'b0;
        done  = 1'b0;
        while (!done) begin
            @(negedge clk_i);
            // requests offered while busy must be ignored
            req_valid_i = $urandom_range(0, 1) == 1;
            if (resp_valid_o || seen) begin
                if (!seen) begin
                    check_equal(VREG_W'(edges), VREG_W'(`VMUL_CHUNKS + 1), "response latency");
                    seen = 1'b1;
                end
                check_equal(VREG_W'(resp_valid_o), VREG_W'(1), "resp_valid_o held");
                check_equal(resp_o.vd, exp_vd, "vd");
                check_equal(VREG_W'(resp_o.be), VREG_W'(exp_be), "be");
                check_equal(VREG_W'(req_ready_o), '0, "req_ready_o while response pending");
                resp_ready_i = $urandom_range(0, 2) == 0;
                done         = resp_ready_i;
            end else begin
                resp_ready_i = $urandom_range(0, 1) == 1;
            end
            edges++;
            if (edges > TIMEOUT) begin
                $display("timeout: response handshake hung, no response transfer");
                end_in_failure();
            end
        end
    endtask

    initial begin
        void'($urandom(41));
        clk_i        = 1'b0;
        async_rst_ni = 1'b0;
        req_valid_i  = 1'b0;
        req_i        = '0;
        resp_ready_i = 1'b0;
        n_resp       = 0;
        n_accept     = 0;
        repeat (3) @(negedge clk_i);
        async_rst_ni = 1'b1;
        check_equal(VREG_W'(req_ready_o), VREG_W'(1), "req_ready_o after reset");
        check_equal(VREG_W'(resp_valid_o), '0, "resp_valid_o after reset");
        for (int i = 0; i < int'(NUM_OPS); i++) begin
            run_op(make_request(i));
        end
        @(negedge clk_i);
        req_valid_i  = 1'b0;
        resp_ready_i = 1'b0;
        check_equal(VREG_W'(n_accept), VREG_W'(NUM_OPS), "requests accepted");
        check_equal(VREG_W'(n_resp), VREG_W'(NUM_OPS), "responses received");
        check_equal(VREG_W'(resp_valid_o), '0, "resp_valid_o after last response");
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== test/vmul_unit_asserts.sv ====
// handshake checks for the vector multiply unit
// bound to the top level

`timescale 1ns/1ps

`include "vmul_config.svh"

module vmul_unit_asserts import vmul_pkg::*; (
    input logic       clk_i,
    input logic       async_rst_ni,
    input logic       req_valid_i,
    input logic       req_ready_o,
    input logic       resp_valid_o,
    input vmul_resp_t resp_o,
    input logic       resp_ready_i
);

    // chunks plus the drain cycle, in sampled clock edges
    localparam int unsigned LAT = `VMUL_CHUNKS + 1;

    // a pending response holds until it is taken
    resp_stable: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o))
        else $error("response changed while resp_ready_i was low");

    // once busy, no request is taken before the response transfer
    ready_low_until_taken: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        !req_ready_o && !(resp_valid_o && resp_ready_i) |=> !req_ready_o)
        else $error("req_ready_o rose before the response was taken");

    resp_latency: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        req_valid_i && req_ready_o |=> !resp_valid_o [*LAT] ##1 resp_valid_o)
        else $error("resp_valid_o did not rise at the expected edge after accept");

endmodule

bind vmul_unit vmul_unit_asserts u_asserts (
    .clk_i        ( clk_i        ),
    .async_rst_ni ( async_rst_ni ),
    .req_valid_i  ( req_valid_i  ),
    .req_ready_o  ( req_ready_o  ),
    .resp_valid_o ( resp_valid_o ),
    .resp_o       ( resp_o       ),
    .resp_ready_i ( resp_ready_i )
);

// ==== source/vmul_unit.sv ====
// vector multiply unit top level
// one operation at a time, processed in chunks through the operand, lane and collect stages

`timescale 1ns/1ps

`include "vmul_config.svh"

module vmul_unit import vmul_pkg::*; (
    input  logic       clk_i,
    input  logic       async_rst_ni,

    input  logic       req_valid_i,
    input  vmul_req_t  req_i,
    output logic       req_ready_o,

    output logic       resp_valid_o,
    output vmul_resp_t resp_o,
    input  logic       resp_ready_i
);

    logic                  load;
    logic                  chunk_valid;
    vmul_mode_t            mode;
    logic [`VMUL_VL_W-1:0] vl;
    vmul_chunk_t           chunk;
    logic                  prod_valid;
    logic [`VMUL_OP_W-1:0] prod;

    vmul_ctrl u_ctrl (
        .clk_i         ( clk_i        ),
        .async_rst_ni  ( async_rst_ni ),
        .req_valid_i   ( req_valid_i  ),
        .req_mode_i    ( req_i.mode   ),
        .req_vl_i      ( req_i.vl     ),
        .req_ready_o   ( req_ready_o  ),
        .resp_ready_i  ( resp_ready_i ),
        .resp_valid_o  ( resp_valid_o ),
        .load_o        ( load         ),
        .chunk_valid_o ( chunk_valid  ),
        .mode_o        ( mode         ),
        .vl_o          ( vl           )
    );

    vmul_operand_shift u_operand_shift (
        .clk_i         ( clk_i        ),
        .async_rst_ni  ( async_rst_ni ),
        .load_i        ( load         ),
        .chunk_valid_i ( chunk_valid  ),
        .mode_i        ( mode         ),
        .vs1_i         ( req_i.vs1    ),
        .vs2_i         ( req_i.vs2    ),
        .vs3_i         ( req_i.vs3    ),
        .chunk_o       ( chunk        )
    );

    vmul_lane_array u_lane_array (
        .clk_i         ( clk_i        ),
        .async_rst_ni  ( async_rst_ni ),
        .chunk_i       ( chunk        ),
        .prod_valid_o  ( prod_valid   ),
        .prod_o        ( prod         )
    );

    vmul_result_collect u_result_collect (
        .clk_i         ( clk_i        ),
        .async_rst_ni  ( async_rst_ni ),
        .prod_valid_i  ( prod_valid   ),
        .prod_i        ( prod         ),
        .sew_i         ( mode.sew     ),
        .vl_i          ( vl           ),
        .resp_o        ( resp_o       )
    );

endmodule

// ==== source/vmul_result_collect.sv ====
// vector multiply result collector
// gathers product chunks into vd and derives the byte enables from vl

`timescale 1ns/1ps

`include "vmul_config.svh"

module vmul_result_collect import vmul_pkg::*; (
    input  logic                  clk_i,
    input  logic                  async_rst_ni,

    input  logic                  prod_valid_i,
    input  logic [`VMUL_OP_W-1:0] prod_i,
    input  vmul_sew_e             sew_i,
    input  logic [`VMUL_VL_W-1:0] vl_i,

    output vmul_resp_t            resp_o
);

    localparam int unsigned NBYTES = `VMUL_VREG_W / 8;

    logic [`VMUL_VREG_W-1:0] vd_q;
    logic [NBYTES-1:0]       be;
    logic [1:0]              esize_log2;

    ////////////////////////////////////////////////////////////////////////////
    // result shift register

    // new chunks enter at the top, so chunk 0 ends at the bottom
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            vd_q <= '0;
        end else if (prod_valid_i) begin
            vd_q <= {prod_i, vd_q[`VMUL_VREG_W-1:`VMUL_OP_W]};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // byte enables

    always_comb begin
        unique case (sew_i)
            SEW_8:   esize_log2 = 2'd0;
            SEW_16:  esize_log2 = 2'd1;
            SEW_32:  esize_log2 = 2'd2;
            default: esize_log2 = 2'd0;
        endcase
    end

    // byte j belongs to element j / size, vl of zero clears every bit
    always_comb begin
        for (int j = 0; j < NBYTES; j++) begin
            be[j] = (int'(j >> esize_log2) < int'(vl_i));
        end
    end

    always_comb begin
        resp_o.vd = vd_q;
        resp_o.be = be;
    end

endmodule

// ==== source/vmul_lane_array.sv ====
// vector multiply lanes
// multiplies every element of one chunk at the selected width, one cycle latency

`timescale 1ns/1ps

`include "vmul_config.svh"

module vmul_lane_array import vmul_pkg::*; (
    input  logic                  clk_i,
    input  logic                  async_rst_ni,

    input  vmul_chunk_t           chunk_i,

    output logic                  prod_valid_o,
    output logic [`VMUL_OP_W-1:0] prod_o
);

    localparam int unsigned N8  = `VMUL_OP_W / 8;
    localparam int unsigned N16 = `VMUL_OP_W / 16;
    localparam int unsigned N32 = `VMUL_OP_W / 32;

    // the element loops assume whole 32-bit words in a chunk
    if (((`VMUL_OP_W & (`VMUL_OP_W - 1)) != 0) || (`VMUL_OP_W < 32) ||
        (`VMUL_OP_W >= `VMUL_VREG_W)) begin : g_bad_op_w
        $fatal(1, "VMUL_OP_W must be a power of two, at least 32 and below VMUL_VREG_W");
    end

    logic                  s1, s2, high;
    logic [`VMUL_OP_W-1:0] acc;
    logic [`VMUL_OP_W-1:0] res_d;
    logic [`VMUL_OP_W-1:0] prod_q;
    logic                  prod_valid_q;

    assign s1   = chunk_i.mode.op1_signed;
    assign s2   = chunk_i.mode.op2_signed;
    assign high = (chunk_i.mode.op == MUL_VMULH);
    // only multiply-accumulate adds the third source
    assign acc  = (chunk_i.mode.op == MUL_VMACC) ? chunk_i.vs3 : '0;

    always_comb begin : lane_mul
        logic signed [8:0]  a8, b8;
        logic signed [16:0] a16, b16;
        logic signed [32:0] a32, b32;
        logic [15:0]        p8;
        logic [31:0]        p16;
        logic [63:0]        p32;
        a8    = '0;
        b8    = '0;
        a16   = '0;
        b16   = '0;
        a32   = '0;
        b32   = '0;
        p8    = '0;
        p16   = '0;
        p32   = '0;
        res_d = '0;
        unique case (chunk_i.mode.sew)
            SEW_8: begin
                for (int i = 0; i < N8; i++) begin
                    a8 = {s1 & chunk_i.vs1[8*i+7], chunk_i.vs1[8*i +: 8]};
                    b8 = {s2 & chunk_i.vs2[8*i+7], chunk_i.vs2[8*i +: 8]};
                    p8 = a8 * b8;
                    res_d[8*i +: 8] = high ? p8[15:8] : (p8[7:0] + acc[8*i +: 8]);
                end
            end
            SEW_16: begin
                for (int i = 0; i < N16; i++) begin
                    a16 = {s1 & chunk_i.vs1[16*i+15], chunk_i.vs1[16*i +: 16]};
                    b16 = {s2 & chunk_i.vs2[16*i+15], chunk_i.vs2[16*i +: 16]};
                    p16 = a16 * b16;
                    res_d[16*i +: 16] = high ? p16[31:16] : (p16[15:0] + acc[16*i +: 16]);
                end
            end
            SEW_32: begin
                for (int i = 0; i < N32; i++) begin
                    a32 = {s1 & chunk_i.vs1[32*i+31], chunk_i.vs1[32*i +: 32]};
                    b32 = {s2 & chunk_i.vs2[32*i+31], chunk_i.vs2[32*i +: 32]};
                    p32 = a32 * b32;
                    res_d[32*i +: 32] = high ? p32[63:32] : (p32[31:0] + acc[32*i +: 32]);
                end
            end
            default: res_d = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            prod_valid_q <= 1'b0;
        end else begin
            prod_valid_q <= chunk_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (chunk_i.valid) begin
            prod_q <= res_d;
        end
    end

    assign prod_valid_o = prod_valid_q;
    assign prod_o       = prod_q;

endmodule

// ==== source/vmul_operand_shift.sv ====
// vector multiply operand stage
// holds the three source vectors and presents one chunk of each per cycle

`timescale 1ns/1ps

`include "vmul_config.svh"

module vmul_operand_shift import vmul_pkg::*; (
    input  logic                    clk_i,
    input  logic                    async_rst_ni,

    input  logic                    load_i,
    input  logic                    chunk_valid_i,
    input  vmul_mode_t              mode_i,
    input  logic [`VMUL_VREG_W-1:0] vs1_i,
    input  logic [`VMUL_VREG_W-1:0] vs2_i,
    input  logic [`VMUL_VREG_W-1:0] vs3_i,

    output vmul_chunk_t             chunk_o
);

    logic [`VMUL_VREG_W-1:0] vs1_q, vs2_q, vs3_q;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            vs1_q <= '0;
            vs2_q <= '0;
            vs3_q <= '0;
        end else if (load_i) begin
            vs1_q <= vs1_i;
            vs2_q <= vs2_i;
            vs3_q <= vs3_i;
        end else if (chunk_valid_i) begin
            // next chunk moves down to the bottom
            vs1_q <= {{`VMUL_OP_W{1'b0}}, vs1_q[`VMUL_VREG_W-1:`VMUL_OP_W]};
            vs2_q <= {{`VMUL_OP_W{1'b0}}, vs2_q[`VMUL_VREG_W-1:`VMUL_OP_W]};
            vs3_q <= {{`VMUL_OP_W{1'b0}}, vs3_q[`VMUL_VREG_W-1:`VMUL_OP_W]};
        end
    end

    always_comb begin
        chunk_o.valid = chunk_valid_i;
        chunk_o.mode  = mode_i;
        chunk_o.vs1   = vs1_q[`VMUL_OP_W-1:0];
        chunk_o.vs2   = vs2_q[`VMUL_OP_W-1:0];
        chunk_o.vs3   = vs3_q[`VMUL_OP_W-1:0];
    end

endmodule

// ==== source/vmul_ctrl.sv ====
// vector multiply control
// owns the request and response handshakes and steps through the chunks

`timescale 1ns/1ps

`include "vmul_config.svh"

module vmul_ctrl import vmul_pkg::*; (
    input  logic                  clk_i,
    input  logic                  async_rst_ni,

    input  logic                  req_valid_i,
    input  vmul_mode_t            req_mode_i,
    input  logic [`VMUL_VL_W-1:0] req_vl_i,
    output logic                  req_ready_o,

    input  logic                  resp_ready_i,
    output logic                  resp_valid_o,

    output logic                  load_o,
    output logic                  chunk_valid_o,
    output vmul_mode_t            mode_o,
    output logic [`VMUL_VL_W-1:0] vl_o
);

    // counts the chunks plus one drain cycle
    localparam int unsigned CNT_W = $clog2(`VMUL_CHUNKS + 1);

    vmul_state_e           state_q, state_d;
    logic [CNT_W-1:0]      cnt_q, cnt_d;
    vmul_mode_t            mode_q;
    logic [`VMUL_VL_W-1:0] vl_q;

    assign req_ready_o   = (state_q == ST_IDLE);
    assign resp_valid_o  = (state_q == ST_HOLD);
    assign load_o        = req_valid_i & req_ready_o;
    assign chunk_valid_o = (state_q == ST_RUN) && (cnt_q < CNT_W'(`VMUL_CHUNKS));
    assign mode_o        = mode_q;
    assign vl_o          = vl_q;

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        unique case (state_q)
            ST_IDLE: begin
                if (load_o) begin
                    state_d = ST_RUN;
                    cnt_d   = '0;
                end
            end
            ST_RUN: begin
                cnt_d = cnt_q + 1'b1;
                // the last product reaches the collector in the drain cycle
                if (cnt_q == CNT_W'(`VMUL_CHUNKS)) begin
                    state_d = ST_HOLD;
                end
            end
            ST_HOLD: begin
                if (resp_ready_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_o) begin
            mode_q <= req_mode_i;
            vl_q   <= req_vl_i;
        end
    end

endmodule

// ==== source/vmul_pkg.sv ====
// vector multiply unit types
// operation and width encodings plus the request, response and chunk structs

`include "vmul_config.svh"

package vmul_pkg;

    typedef enum logic [1:0] {
        MUL_VMUL  = 2'd0,
        MUL_VMULH = 2'd1,
        MUL_VMACC = 2'd2
    } vmul_op_e;

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } vmul_sew_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_HOLD = 2'd2
    } vmul_state_e;

    // the part of a request the lanes act on
    typedef struct packed {
        vmul_op_e  op;
        logic      op1_signed;
        logic      op2_signed;
        vmul_sew_e sew;
    } vmul_mode_t;

    typedef struct packed {
        vmul_mode_t                mode;
        logic [`VMUL_VL_W-1:0]     vl;
        logic [`VMUL_VREG_W-1:0]   vs1;
        logic [`VMUL_VREG_W-1:0]   vs2;
        logic [`VMUL_VREG_W-1:0]   vs3;
    } vmul_req_t;

    typedef struct packed {
        logic [`VMUL_VREG_W-1:0]   vd;
        logic [`VMUL_VREG_W/8-1:0] be;
    } vmul_resp_t;

    // operand stage to lanes
    typedef struct packed {
        logic                      valid;
        vmul_mode_t                mode;
        logic [`VMUL_OP_W-1:0]     vs1;
        logic [`VMUL_OP_W-1:0]     vs2;
        logic [`VMUL_OP_W-1:0]     vs3;
    } vmul_chunk_t;

endpackage

// ==== source/vmul_config.svh ====
// vector multiply unit configuration
// widths of the vector registers, the chunks and the vector length

`ifndef VMUL_CONFIG_SVH
`define VMUL_CONFIG_SVH

// vector register width in bits
`define VMUL_VREG_W 128

// chunk width handled per cycle, a power of two of at least 32 and below VMUL_VREG_W
`define VMUL_OP_W 32

// chunks per vector register
`define VMUL_CHUNKS (`VMUL_VREG_W / `VMUL_OP_W)

// vector length in elements, 0 to 16
`define VMUL_VL_W 5

`endif
